/* logic/wb_config_pkg.sv */
// Write-back subsystem sizing constants
// Default values for the top-level parameters of the write-back,
// retirement and register-file blocks
`default_nettype none

package wb_config_pkg;

    //////////////////////////////////////////////////
    // Datapath

    // Result and register word width
    localparam int XLEN = 32;

    //////////////////////////////////////////////////
    // Completion and tracking

    // Execution units that report results by slot ID
    localparam int NUM_WB_UNITS = 2;

    // Slot IDs in flight at once, power of two
    localparam int MAX_INFLIGHT_COUNT = 4;

    //////////////////////////////////////////////////
    // Architectural state

    // Integer registers, x0 hardwired to zero
    localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

/* logic/wb_types_pkg.sv */
// Write-back subsystem types
// Slot IDs, register addresses, result words and the per-slot
// packet that is kept from issue until retirement
`default_nettype none

package wb_types_pkg;

    import wb_config_pkg::*;

    //////////////////////////////////////////////////
    // Scalar types

    // One slot of the circular ID tracker
    typedef logic [$clog2(MAX_INFLIGHT_COUNT)-1:0] instruction_id_t;

    // Architectural register index
    typedef logic [$clog2(NUM_REGS)-1:0] rd_addr_t;

    // Unit result, also the register file word
    typedef logic [XLEN-1:0] wb_data_t;

    //////////////////////////////////////////////////
    // In-flight packet

    // Stored at issue, read back at retirement
    typedef struct packed {
        // Destination register
        rd_addr_t rd_addr;
        // Destination is not x0
        logic rd_addr_nzero;
        // Completes through the store port, no register write
        logic is_store;
    } inflight_packet_t;

endpackage

`default_nettype wire

/* logic/id_tracking.sv */
// Circular slot ID allocator
// Hands out IDs in order at issue and frees the oldest at retirement,
// keeps an occupancy count for back-pressure and empty detection
`timescale 1ns/1ps
`default_nettype none

module id_tracking #(
    parameter int MAX_INFLIGHT_COUNT = wb_config_pkg::MAX_INFLIGHT_COUNT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issued,
    input  logic                          retired,
    output wb_types_pkg::instruction_id_t next_id,
    output wb_types_pkg::instruction_id_t oldest_id,
    output logic                          id_available,
    output logic                          empty
);

    import wb_types_pkg::*;

    // Count has to reach the full depth, so one extra bit
    localparam int COUNT_W = $clog2(MAX_INFLIGHT_COUNT + 1);

    logic [COUNT_W-1:0] inflight_count;

    //////////////////////////////////////////////////
    // Pointers

    // Both wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id   <= '0;
            oldest_id <= '0;
        end else begin
            // Allocate on accepted issue
            if (issued) begin
                next_id <= instruction_id_t'(next_id + 1'b1);
            end
            // Free the oldest slot on retirement
            if (retired) begin
                oldest_id <= instruction_id_t'(oldest_id + 1'b1);
            end
        end
    end

    //////////////////////////////////////////////////
    // Occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({issued, retired})
                // Issue only
                2'b10: inflight_count <= inflight_count + 1'b1;
                // Retire only
                2'b01: inflight_count <= inflight_count - 1'b1;
                // Both or neither, no change
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Flags straight from the count
    assign id_available = (inflight_count < COUNT_W'(MAX_INFLIGHT_COUNT));
    assign empty        = (inflight_count == '0);

endmodule

`default_nettype wire

/* logic/write_back.sv */
// Write-back and in-order retirement
// Collects out-of-order unit and store completions by slot ID,
// retires the oldest slot once done and drives the register file
// write one cycle later
`timescale 1ns/1ps
`default_nettype none

module write_back #(
    parameter int NUM_WB_UNITS       = wb_config_pkg::NUM_WB_UNITS,
    parameter int MAX_INFLIGHT_COUNT = wb_config_pkg::MAX_INFLIGHT_COUNT
) (
    input  logic                           clk,
    input  logic                           rst,
    // Issue side
    input  logic                           issued,
    input  wb_types_pkg::instruction_id_t  issue_id,
    input  wb_types_pkg::inflight_packet_t issue_packet,
    // Unit completions
    input  logic [NUM_WB_UNITS-1:0]        unit_done,
    input  wb_types_pkg::instruction_id_t  unit_id [NUM_WB_UNITS],
    input  wb_types_pkg::wb_data_t         unit_rd [NUM_WB_UNITS],
    // Store completions
    input  logic                           store_complete,
    input  wb_types_pkg::instruction_id_t  store_done_id,
    // From the ID tracker
    input  wb_types_pkg::instruction_id_t  oldest_id,
    input  logic                           empty,
    output logic                           retired,
    // Register file write
    output logic                           rf_we,
    output wb_types_pkg::rd_addr_t         rf_waddr,
    output wb_types_pkg::wb_data_t         rf_wdata,
    output logic                           instruction_complete
);

    import wb_types_pkg::*;

    // Unit select width, at least one bit for a single unit
    localparam int SEL_W = (NUM_WB_UNITS > 1) ? $clog2(NUM_WB_UNITS) : 1;

    // Per-slot storage
    inflight_packet_t packet_table [MAX_INFLIGHT_COUNT];
    wb_data_t         rds_by_id [MAX_INFLIGHT_COUNT];
    logic [SEL_W-1:0] unit_select [MAX_INFLIGHT_COUNT];

    // Per-slot done tracking
    logic [MAX_INFLIGHT_COUNT-1:0] unit_hit;
    logic [MAX_INFLIGHT_COUNT-1:0] id_done_new;
    logic [MAX_INFLIGHT_COUNT-1:0] id_done_r;
    logic [MAX_INFLIGHT_COUNT-1:0] id_done;
    logic [MAX_INFLIGHT_COUNT-1:0] id_retired;
    logic [MAX_INFLIGHT_COUNT-1:0] id_retired_r;

    // Retirement stage
    logic             retired_r;
    instruction_id_t  retired_id_r;
    inflight_packet_t retired_packet;

    //////////////////////////////////////////////////
    // Completion decode

    // Units never report the same ID in one cycle
    always_comb begin
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            unit_hit[i]    = 1'b0;
            unit_select[i] = '0;
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                if (unit_done[j] && (unit_id[j] == instruction_id_t'(i))) begin
                    unit_hit[i]    = 1'b1;
                    unit_select[i] = SEL_W'(j);
                end
            end
            // Stores carry no result, only the done flag
            id_done_new[i] = unit_hit[i] |
                             (store_complete && (store_done_id == instruction_id_t'(i)));
        end
    end

    // Result capture by slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            if (unit_hit[i]) begin
                rds_by_id[i] <= unit_rd[unit_select[i]];
            end
        end
    end

    //////////////////////////////////////////////////
    // Packet table

    // Written at each accepted issue
    always_ff @(posedge clk) begin
        if (issued) begin
            packet_table[issue_id] <= issue_packet;
        end
    end

    //////////////////////////////////////////////////
    // Done bits and retirement

    // One-hot of the slot retiring this cycle
    always_comb begin
        id_retired            = '0;
        id_retired[oldest_id] = retired;
    end

    // Stored done bits drop the cycle after retirement,
    // same-cycle completions count immediately
    assign id_done = (id_done_r & ~id_retired_r) | id_done_new;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_done_r    <= '0;
            id_retired_r <= '0;
        end else begin
            id_done_r    <= id_done;
            id_retired_r <= id_retired;
        end
    end

    // Oldest slot retires as soon as done
    assign retired = id_done[oldest_id] & ~empty;

    //////////////////////////////////////////////////
    // Register file write

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_r <= 1'b0;
        end else begin
            retired_r <= retired;
        end
    end

    // Payload of the retiring slot
    always_ff @(posedge clk) begin
        retired_id_r   <= oldest_id;
        retired_packet <= packet_table[oldest_id];
    end

    // Pulses for every retired non-store, x0 included
    assign instruction_complete = retired_r & ~retired_packet.is_store;

    // x0 destinations never reach the register file
    assign rf_we    = instruction_complete & retired_packet.rd_addr_nzero;
    assign rf_waddr = retired_packet.rd_addr;
    assign rf_wdata = rds_by_id[retired_id_r];

endmodule

`default_nettype wire

/* logic/register_file.sv */
// Architectural register file
// One synchronous write port and one combinational read port,
// register 0 stays zero
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int NUM_REGS = wb_config_pkg::NUM_REGS
) (
    input  logic                   clk,
    input  logic                   rst,
    // Write port
    input  logic                   we,
    input  wb_types_pkg::rd_addr_t waddr,
    input  wb_types_pkg::wb_data_t wdata,
    // Read port
    input  wb_types_pkg::rd_addr_t raddr,
    output wb_types_pkg::wb_data_t rdata
);

    import wb_types_pkg::*;

    wb_data_t regs [NUM_REGS];

    //////////////////////////////////////////////////
    // Write

    // Whole file cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // Read

    // Combinational, x0 forced to zero
    always_comb begin
        if (raddr == '0) begin
            rdata = '0;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule

`default_nettype wire

/* logic/wb_subsystem.sv */
// Write-back subsystem top level
// Connects the slot ID tracker, write-back and retirement logic
// and the register file to the issue, unit and read ports
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem #(
    parameter int XLEN               = wb_config_pkg::XLEN,
    parameter int NUM_WB_UNITS       = wb_config_pkg::NUM_WB_UNITS,
    parameter int MAX_INFLIGHT_COUNT = wb_config_pkg::MAX_INFLIGHT_COUNT,
    parameter int NUM_REGS           = wb_config_pkg::NUM_REGS
) (
    input  logic                           clk,
    input  logic                           rst,
    // Issue
    input  logic                           issue,
    input  wb_types_pkg::inflight_packet_t issue_packet,
    output wb_types_pkg::instruction_id_t  issue_id,
    output logic                           id_available,
    // Units
    input  logic [NUM_WB_UNITS-1:0]        unit_done,
    input  wb_types_pkg::instruction_id_t  unit_id [NUM_WB_UNITS],
    input  logic [XLEN-1:0]                unit_rd [NUM_WB_UNITS],
    // Stores
    input  logic                           store_complete,
    input  wb_types_pkg::instruction_id_t  store_done_id,
    // Status
    output logic                           instruction_queue_empty,
    output logic                           instruction_complete,
    // Architectural read
    input  wb_types_pkg::rd_addr_t         rs_addr,
    output logic [XLEN-1:0]                rs_data
);

    import wb_types_pkg::*;

    logic            issue_accepted;
    instruction_id_t oldest_id;
    logic            retired;
    logic            rf_we;
    rd_addr_t        rf_waddr;
    wb_data_t        rf_wdata;

    // Issue is ignored while all slots are taken
    assign issue_accepted = issue & id_available;

    //////////////////////////////////////////////////
    // Slot IDs
    id_tracking #(
        .MAX_INFLIGHT_COUNT(MAX_INFLIGHT_COUNT)
    ) u_id_tracking (
        .clk         (clk),
        .rst         (rst),
        .issued      (issue_accepted),
        .retired     (retired),
        .next_id     (issue_id),
        .oldest_id   (oldest_id),
        .id_available(id_available),
        .empty       (instruction_queue_empty)
    );

    //////////////////////////////////////////////////
    // Completion and retirement
    write_back #(
        .NUM_WB_UNITS      (NUM_WB_UNITS),
        .MAX_INFLIGHT_COUNT(MAX_INFLIGHT_COUNT)
    ) u_write_back (
        .clk                 (clk),
        .rst                 (rst),
        .issued              (issue_accepted),
        .issue_id            (issue_id),
        .issue_packet        (issue_packet),
        .unit_done           (unit_done),
        .unit_id             (unit_id),
        .unit_rd             (unit_rd),
        .store_complete      (store_complete),
        .store_done_id       (store_done_id),
        .oldest_id           (oldest_id),
        .empty               (instruction_queue_empty),
        .retired             (retired),
        .rf_we               (rf_we),
        .rf_waddr            (rf_waddr),
        .rf_wdata            (rf_wdata),
        .instruction_complete(instruction_complete)
    );

    //////////////////////////////////////////////////
    // Architectural state
    register_file #(
        .NUM_REGS(NUM_REGS)
    ) u_register_file (
        .clk  (clk),
        .rst  (rst),
        .we   (rf_we),
        .waddr(rf_waddr),
        .wdata(rf_wdata),
        .raddr(rs_addr),
        .rdata(rs_data)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset source
// Free-running clock, synchronous reset held high for a fixed number
// of rising edges and released just after an edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int CLK_PERIOD_NS  = 40,
    parameter int RESET_CYCLES   = 16,
    parameter int RESET_DELAY_NS = 2
) (
    output logic clk,
    output logic rst
);

    // Clock starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the edge, like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RESET_DELAY_NS) rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_wb_subsystem.sv */
// Write-back subsystem testbench
// Issues instruction streams, completes them out of order through both
// units and the store port, checks retirement, latency and the register
// file against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsystem;

    import wb_config_pkg::*;
    import wb_types_pkg::*;

    localparam int          CLK_PERIOD_NS   = 40;
    localparam int          RESET_CYCLES    = 16;
    localparam int          DRIVE_DELAY_NS  = 2;
    localparam logic [31:0] LFSR_SEED       = 32'h16e6_2a31;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;
    // Issues per test: out of order, back-pressure, stores, stream, latency
    localparam int          TOTAL_ISSUES    = 4 + 8 + 4 + 200 + 2;
    localparam int          WATCHDOG_CYCLES = TOTAL_ISSUES * 20 + RESET_CYCLES;

    logic clk;
    logic rst;

    // DUT inputs
    logic                    issue;
    inflight_packet_t        issue_packet;
    logic [NUM_WB_UNITS-1:0] unit_done;
    instruction_id_t         unit_id [NUM_WB_UNITS];
    wb_data_t                unit_rd [NUM_WB_UNITS];
    logic                    store_complete;
    instruction_id_t         store_done_id;
    rd_addr_t                rs_addr;

    // DUT outputs
    instruction_id_t issue_id;
    logic            id_available;
    logic            instruction_queue_empty;
    logic            instruction_complete;
    wb_data_t        rs_data;

    // Reference state and issued slots
    wb_data_t          ref_regs [NUM_REGS];
    logic              slot_store [MAX_INFLIGHT_COUNT];
    wb_data_t          slot_data [MAX_INFLIGHT_COUNT];
    instruction_id_t   pending [$];
    instruction_id_t   exp_next_id;
    logic [31:0]       lfsr_state;
    logic              sweep_active;

    // Main sequence counters
    int nonstore_issued;
    int check_count;
    int error_count;
    int test_errors_start;
    int tests_run;
    int tests_failed;

    // Owned by the comparing process
    int complete_pulses = 0;
    int compare_checks  = 0;
    int compare_errors  = 0;

    tb_clock_gen #(
        .CLK_PERIOD_NS(CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_tb_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    wb_subsystem #(
        .XLEN              (XLEN),
        .NUM_WB_UNITS      (NUM_WB_UNITS),
        .MAX_INFLIGHT_COUNT(MAX_INFLIGHT_COUNT),
        .NUM_REGS          (NUM_REGS)
    ) u_wb_subsystem (
        .clk                    (clk),
        .rst                    (rst),
        .issue                  (issue),
        .issue_packet           (issue_packet),
        .issue_id               (issue_id),
        .id_available           (id_available),
        .unit_done              (unit_done),
        .unit_id                (unit_id),
        .unit_rd                (unit_rd),
        .store_complete         (store_complete),
        .store_done_id          (store_done_id),
        .instruction_queue_empty(instruction_queue_empty),
        .instruction_complete   (instruction_complete),
        .rs_addr                (rs_addr),
        .rs_data                (rs_data)
    );

    //////////////////////////////////////////////////
    // Random numbers and reference model

    // Right-shifting Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    // Register value after one retirement; stores and x0 write nothing
    function automatic wb_data_t ref_reg_after(input wb_data_t old_val, input int idx,
                                               input rd_addr_t rd, input logic is_store,
                                               input wb_data_t data);
        if (!is_store && (rd != '0) && (int'(rd) == idx)) begin
            return data;
        end
        return old_val;
    endfunction

    //////////////////////////////////////////////////
    // Comparing process

    // Sampled mid-cycle, away from both drive and clock edges
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (instruction_complete === 1'b1) begin
                complete_pulses++;
            end
            if (sweep_active) begin
                compare_checks++;
                assert (rs_data === ref_regs[rs_addr]) else begin
                    $display("mismatch at %0t: rs_data (x%0d) got %h expected %h",
                             $time, rs_addr, rs_data, ref_regs[rs_addr]);
                    compare_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Helper tasks

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY_NS);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_completions();
        unit_done      = '0;
        store_complete = 1'b0;
        store_done_id  = '0;
        for (int u = 0; u < NUM_WB_UNITS; u++) begin
            unit_id[u] = '0;
            unit_rd[u] = '0;
        end
    endtask

    // Waits for a free slot, then issues for exactly one cycle
    task automatic issue_instr(input rd_addr_t rd, input logic is_store,
                               input wb_data_t data);
        instruction_id_t slot;
        while (id_available !== 1'b1) begin
            next_cycle();
        end
        issue                      = 1'b1;
        issue_packet.rd_addr       = rd;
        issue_packet.rd_addr_nzero = (rd != '0);
        issue_packet.is_store      = is_store;
        slot                       = issue_id;
        // Slots are handed out in wrapping order
        check_value("issue_id", 32'(issue_id), 32'(exp_next_id));
        exp_next_id      = instruction_id_t'(exp_next_id + 1'b1);
        slot_store[slot] = is_store;
        slot_data[slot]  = data;
        pending.push_back(slot);
        if (!is_store) begin
            nonstore_issued++;
        end
        // Retirement is in issue order, so the model updates here
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = ref_reg_after(ref_regs[i], i, rd, is_store, data);
        end
        next_cycle();
        issue = 1'b0;
    endtask

    task automatic issue_random(input logic allow_store);
        rd_addr_t rd;
        logic     is_store;
        wb_data_t data;
        rd       = rd_addr_t'(take_bits(5));
        is_store = allow_store & (take_bits(2) == 32'd0);
        data     = take_bits(32);
        issue_instr(rd, is_store, data);
    endtask

    // Random order, up to two completions per cycle on free ports
    task automatic complete_pending();
        int idx;
        int u;
        int attempts;
        instruction_id_t slot;
        while (pending.size() > 0) begin
            clear_completions();
            attempts = 1 + int'(take_bits(1));
            for (int a = 0; a < attempts; a++) begin
                if (pending.size() > 0) begin
                    idx  = int'(take_bits(3)) % pending.size();
                    slot = pending[idx];
                    if (slot_store[slot]) begin
                        if (!store_complete) begin
                            store_complete = 1'b1;
                            store_done_id  = slot;
                            pending.delete(idx);
                        end
                    end else begin
                        u = int'(take_bits(1)) % NUM_WB_UNITS;
                        if (unit_done[u]) begin
                            u = (u + 1) % NUM_WB_UNITS;
                        end
                        if (!unit_done[u]) begin
                            unit_done[u] = 1'b1;
                            unit_id[u]   = slot;
                            unit_rd[u]   = slot_data[slot];
                            pending.delete(idx);
                        end
                    end
                end
            end
            next_cycle();
        end
        clear_completions();
    endtask

    // Two more cycles let the last write land
    task automatic drain_queue();
        while (instruction_queue_empty !== 1'b1) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic sweep_registers();
        sweep_active = 1'b1;
        for (int a = 0; a < NUM_REGS; a++) begin
            rs_addr = rd_addr_t'(a);
            next_cycle();
        end
        sweep_active = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count + compare_errors - test_errors_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
        test_errors_start = error_count + compare_errors;
    endtask

    // Oldest completes in cycle N, pulse in N+1, readable in N+2
    task automatic check_latency(input int u);
        rd_addr_t        rd;
        wb_data_t        data;
        wb_data_t        old_val;
        instruction_id_t slot;
        rd = rd_addr_t'(take_bits(5));
        if (rd == '0) begin
            rd = rd_addr_t'(1);
        end
        data    = take_bits(32);
        old_val = ref_regs[rd];
        rs_addr = rd;
        issue_instr(rd, 1'b0, data);
        slot         = pending.pop_front();
        unit_done[u] = 1'b1;
        unit_id[u]   = slot;
        unit_rd[u]   = data;
        @(negedge clk);
        check_value("instruction_complete", 32'(instruction_complete), 32'd0);
        next_cycle();
        clear_completions();
        @(negedge clk);
        check_value("instruction_complete", 32'(instruction_complete), 32'd1);
        check_value("rs_data", rs_data, old_val);
        next_cycle();
        @(negedge clk);
        check_value("instruction_complete", 32'(instruction_complete), 32'd0);
        check_value("rs_data", rs_data, ref_regs[rd]);
        next_cycle();
    endtask

    //////////////////////////////////////////////////
    // Watchdog

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        rd_addr_t same_rd;
        int       pulses_start;
        int       nonstores_start;
        int       stream_issued;
        int       batch;

        issue             = 1'b0;
        issue_packet      = '0;
        rs_addr           = '0;
        sweep_active      = 1'b0;
        exp_next_id       = '0;
        lfsr_state        = LFSR_SEED;
        nonstore_issued   = 0;
        check_count       = 0;
        error_count       = 0;
        test_errors_start = 0;
        tests_run         = 0;
        tests_failed      = 0;
        clear_completions();
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end

        @(negedge rst);
        next_cycle();

        // After reset
        check_value("instruction_queue_empty", 32'(instruction_queue_empty), 32'd1);
        check_value("id_available", 32'(id_available), 32'd1);
        check_value("instruction_complete", 32'(instruction_complete), 32'd0);
        sweep_registers();
        finish_test("after reset");

        // Out-of-order completion, two writes to one register
        same_rd = rd_addr_t'(take_bits(5));
        if (same_rd == '0) begin
            same_rd = rd_addr_t'(1);
        end
        issue_instr(same_rd, 1'b0, take_bits(32));
        issue_random(1'b0);
        issue_instr(same_rd, 1'b0, take_bits(32));
        issue_random(1'b0);
        complete_pending();
        drain_queue();
        sweep_registers();
        finish_test("out-of-order completion");

        // Back-pressure with a held issue request
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            issue_random(1'b0);
        end
        issue = 1'b1;
        repeat (3) begin
            check_value("id_available", 32'(id_available), 32'd0);
            check_value("issue_id", 32'(issue_id), 32'(exp_next_id));
            next_cycle();
        end
        issue = 1'b0;
        complete_pending();
        drain_queue();
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            issue_random(1'b0);
        end
        complete_pending();
        drain_queue();
        sweep_registers();
        finish_test("back-pressure");

        // Stores and x0 destinations
        pulses_start = complete_pulses;
        issue_instr(rd_addr_t'(5), 1'b1, take_bits(32));
        issue_instr(rd_addr_t'(0), 1'b0, take_bits(32));
        issue_instr(rd_addr_t'(9), 1'b1, take_bits(32));
        issue_instr(rd_addr_t'(0), 1'b0, take_bits(32));
        complete_pending();
        drain_queue();
        check_value("instruction_complete pulses", 32'(complete_pulses - pulses_start), 32'd2);
        sweep_registers();
        finish_test("stores and x0");

        // Random stream in batches of one to four
        pulses_start    = complete_pulses;
        nonstores_start = nonstore_issued;
        stream_issued   = 0;
        while (stream_issued < 200) begin
            batch = 1 + int'(take_bits(2));
            if (batch > 200 - stream_issued) begin
                batch = 200 - stream_issued;
            end
            for (int i = 0; i < batch; i++) begin
                issue_random(1'b1);
            end
            stream_issued += batch;
            complete_pending();
        end
        drain_queue();
        check_value("instruction_complete pulses", 32'(complete_pulses - pulses_start),
                    32'(nonstore_issued - nonstores_start));
        check_value("instruction_queue_empty", 32'(instruction_queue_empty), 32'd1);
        sweep_registers();
        finish_test("random stream");

        // Retirement latency on each unit
        check_latency(0);
        check_latency(NUM_WB_UNITS - 1);
        finish_test("retirement latency");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, check_count + compare_checks, error_count + compare_errors);
        if ((error_count + compare_errors) == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/wb_config_pkg.sv
logic/wb_types_pkg.sv
logic/id_tracking.sv
logic/write_back.sv
logic/register_file.sv
logic/wb_subsystem.sv
verif/tb_clock_gen.sv
verif/tb_wb_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the write-back subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_subsystem -f files.f -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1
